// ==== exec_cluster.f ====
+incdir+bench
logic/core_pkg.sv
logic/wb_pkg.sv
logic/fu_result_if.sv
logic/scalar_alu.sv
logic/mul_unit.sv
logic/wb_arbiter.sv
logic/exec_cluster.sv
bench/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute cluster testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exec_cluster_tb -f exec_cluster.f
out=$(./obj_dir/Vexec_cluster_tb)
echo "$out"
echo "$out" | grep -q "TEST PASS"

// ==== bench/exec_cluster_checks.svh ====
/* reference result model for the execute cluster
   and compare tasks on the writeback record */
`ifndef EXEC_CLUSTER_CHECKS_SVH
`define EXEC_CLUSTER_CHECKS_SVH

function automatic wb_pkg::wb_result_t model_alu(logic [3:0] op, core_pkg::word_t a,
    core_pkg::word_t b, core_pkg::robid_t id, core_pkg::preg_t rd);
  wb_pkg::wb_result_t r;
  r = '0;
  r.robid = id;
  r.rd = rd;
  case (op)
    wb_pkg::ALU_ADD: r.result = a + b;
    wb_pkg::ALU_SUB: r.result = a - b;
    wb_pkg::ALU_AND: r.result = a & b;
    wb_pkg::ALU_OR:  r.result = a | b;
    wb_pkg::ALU_XOR: r.result = a ^ b;
    wb_pkg::ALU_SLL: r.result = a << b[4:0];
    wb_pkg::ALU_SRL: r.result = a >> b[4:0];
    wb_pkg::ALU_SLT: r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    default: begin
      r.error = 1'b1;
      r.ecause = core_pkg::ECAUSE_ILLEGAL_INSN;
    end
  endcase
  return r;
endfunction

function automatic wb_pkg::wb_result_t model_mul(logic [1:0] op, core_pkg::word_t a,
    core_pkg::word_t b, core_pkg::robid_t id, core_pkg::preg_t rd);
  wb_pkg::wb_result_t r;
  longint sp;
  logic [63:0] up;
  r = '0;
  r.robid = id;
  r.rd = rd;
  sp = longint'($signed(a)) * longint'($signed(b));
  up = {32'd0, a} * {32'd0, b};
  case (op)
    wb_pkg::OP_MUL:   r.result = up[31:0];
    wb_pkg::OP_MULH:  r.result = sp[63:32];
    wb_pkg::OP_MULHU: r.result = up[63:32];
    default: begin
      r.error = 1'b1;
      r.ecause = core_pkg::ECAUSE_ILLEGAL_INSN;
    end
  endcase
  return r;
endfunction

task automatic compare_result(wb_pkg::wb_result_t got, wb_pkg::wb_result_t exp, string what);
  if (got !== exp) begin
    errors++;
    $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_flag(logic got, logic exp, string what);
  if (got !== exp) begin
    errors++;
    $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic compare_latency(int got, int exp, string what);
  if (got != exp) begin
    errors++;
    $display("MISMATCH at %0t: %s, got %0d cycles expected %0d", $time, what, got, exp);
  end
endtask

`endif

// ==== bench/exec_cluster_tb.sv ====
`timescale 1ns/1ps
/* testbench for the execute cluster, directed tests
   on the common data bus against a reference model */
module exec_cluster_tb;

  localparam int TIMEOUT = 50;

  logic               clk;
  logic               rst;
  logic               rob_flush;
  logic               alu0_valid;
  wb_pkg::alu_op_t    alu0_op;
  core_pkg::word_t    alu0_a, alu0_b;
  core_pkg::robid_t   alu0_robid;
  core_pkg::preg_t    alu0_rd;
  logic               alu0_ready;
  logic               alu1_valid;
  wb_pkg::alu_op_t    alu1_op;
  core_pkg::word_t    alu1_a, alu1_b;
  core_pkg::robid_t   alu1_robid;
  core_pkg::preg_t    alu1_rd;
  logic               alu1_ready;
  logic               mul0_valid;
  wb_pkg::mul_op_t    mul0_op;
  core_pkg::word_t    mul0_a, mul0_b;
  core_pkg::robid_t   mul0_robid;
  core_pkg::preg_t    mul0_rd;
  logic               mul0_ready;
  logic               mul1_valid;
  wb_pkg::mul_op_t    mul1_op;
  core_pkg::word_t    mul1_a, mul1_b;
  core_pkg::robid_t   mul1_robid;
  core_pkg::preg_t    mul1_rd;
  logic               mul1_ready;
  logic               lsq_valid;
  logic               lsq_error;
  core_pkg::ecause_t  lsq_ecause;
  core_pkg::robid_t   lsq_robid;
  core_pkg::preg_t    lsq_rd;
  core_pkg::word_t    lsq_result;
  logic               lsq_stall;
  logic               csr_valid;
  logic               csr_error;
  core_pkg::ecause_t  csr_ecause;
  core_pkg::robid_t   csr_robid;
  core_pkg::preg_t    csr_rd;
  core_pkg::word_t    csr_result;
  logic               wb_valid;
  logic               wb_error;
  core_pkg::ecause_t  wb_ecause;
  core_pkg::robid_t   wb_robid;
  core_pkg::preg_t    wb_rd;
  core_pkg::word_t    wb_result;

  // per-source stimulus, index is the source number
  bit                 iv [5];
  logic [3:0]         iop [5];
  core_pkg::word_t    ia [5];
  core_pkg::word_t    ib [5];
  core_pkg::robid_t   iid [5];
  wb_pkg::wb_result_t exp_u [5];
  core_pkg::robid_t   next_id;
  logic [31:0]        lfsr_q;
  int                 errors;
  int                 tests;
  int                 failed;

  `include "exec_cluster_checks.svh"

  exec_cluster #(.MUL_STAGES(3)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic wb_pkg::wb_result_t expect_for(int u);
    wb_pkg::wb_result_t r;
    core_pkg::preg_t rd;
    rd = ~iid[u][5:0];
    if (u < 2) begin
      r = model_alu(iop[u], ia[u], ib[u], iid[u], rd);
    end else if (u < 4) begin
      r = model_mul(iop[u][1:0], ia[u], ib[u], iid[u], rd);
    end else begin
      // lsq result passes through unchanged
      r = '0;
      r.error = ib[u][0];
      r.ecause = ib[u][5:1];
      r.robid = iid[u];
      r.rd = rd;
      r.result = ia[u];
    end
    return r;
  endfunction

  function automatic wb_pkg::wb_result_t bus_value();
    wb_pkg::wb_result_t r;
    r.error = wb_error;
    r.ecause = wb_ecause;
    r.robid = wb_robid;
    r.rd = wb_rd;
    r.result = wb_result;
    return r;
  endfunction

  function automatic logic unit_ready(int u);
    case (u)
      0: return alu0_ready;
      1: return alu1_ready;
      2: return mul0_ready;
      3: return mul1_ready;
      default: return !lsq_stall;
    endcase
  endfunction

  task automatic load_unit(int u, logic [3:0] op);
    iv[u] = 1'b1;
    iop[u] = op;
    ia[u] = rand_bits(32);
    ib[u] = rand_bits(32);
    iid[u] = next_id;
    next_id = next_id + 8'd1;
    exp_u[u] = expect_for(u);
  endtask

  task automatic drive_ports();
    alu0_valid <= iv[0];
    alu0_op <= wb_pkg::alu_op_t'(iop[0]);
    alu0_a <= ia[0];
    alu0_b <= ib[0];
    alu0_robid <= iid[0];
    alu0_rd <= ~iid[0][5:0];
    alu1_valid <= iv[1];
    alu1_op <= wb_pkg::alu_op_t'(iop[1]);
    alu1_a <= ia[1];
    alu1_b <= ib[1];
    alu1_robid <= iid[1];
    alu1_rd <= ~iid[1][5:0];
    mul0_valid <= iv[2];
    mul0_op <= wb_pkg::mul_op_t'(iop[2][1:0]);
    mul0_a <= ia[2];
    mul0_b <= ib[2];
    mul0_robid <= iid[2];
    mul0_rd <= ~iid[2][5:0];
    mul1_valid <= iv[3];
    mul1_op <= wb_pkg::mul_op_t'(iop[3][1:0]);
    mul1_a <= ia[3];
    mul1_b <= ib[3];
    mul1_robid <= iid[3];
    mul1_rd <= ~iid[3][5:0];
    lsq_valid <= iv[4];
    lsq_error <= ib[4][0];
    lsq_ecause <= ib[4][5:1];
    lsq_robid <= iid[4];
    lsq_rd <= ~iid[4][5:0];
    lsq_result <= ia[4];
  endtask

  task automatic wait_bus(output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_valid && n < TIMEOUT);
    if (!wb_valid) begin
      errors++;
      $display("timeout: no result reached the bus within %0d cycles", n);
    end
  endtask

  task automatic finish_test(string name, int err0);
    tests++;
    if (errors != err0) begin
      failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    @(negedge clk);
    compare_flag(wb_valid, 1'b0, "wb_valid after reset");
    compare_flag(lsq_stall, 1'b0, "lsq_stall after reset");
    for (int u = 0; u < 4; u++) begin
      compare_flag(unit_ready(u), 1'b1, "ready after reset");
    end
    finish_test("reset state", err0);
  endtask

  task automatic test_alu_ops();
    int err0;
    int lat;
    err0 = errors;
    // eight legal codes, then one illegal
    for (int k = 0; k < 9; k++) begin
      @(posedge clk);
      load_unit(0, (k < 8) ? 4'(k) : 4'd13);
      drive_ports();
      @(posedge clk);
      iv[0] = 1'b0;
      drive_ports();
      wait_bus(lat);
      compare_latency(lat, 2, "alu latency");
      compare_result(bus_value(), exp_u[0], "alu result");
    end
    finish_test("alu opcodes", err0);
  endtask

  task automatic test_mul_stream();
    int err0;
    wb_pkg::wb_result_t exp_q [$];
    err0 = errors;
    for (int k = 0; k < 4; k++) begin
      @(posedge clk);
      load_unit(2, 4'(k));
      exp_q.push_back(exp_u[2]);
      drive_ports();
      @(negedge clk);
      compare_flag(wb_valid, 1'b0, "mul result too early");
    end
    @(posedge clk);
    iv[2] = 1'b0;
    drive_ports();
    // first product four cycles after its issue, then one per cycle
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      compare_flag(wb_valid, 1'b1, "mul stream valid");
      compare_result(bus_value(), exp_q.pop_front(), "mul stream result");
    end
    finish_test("multiplier stream", err0);
  endtask

  task automatic test_contention();
    int err0;
    bit busy;
    int order [5];
    wb_pkg::wb_result_t exp_by_id [core_pkg::robid_t];
    err0 = errors;
    order = '{wb_pkg::SRC_LSQ, wb_pkg::SRC_MUL1, wb_pkg::SRC_MUL0,
              wb_pkg::SRC_ALU1, wb_pkg::SRC_ALU0};
    // line up all five sources so they reach staging at one edge
    @(posedge clk);
    load_unit(2, 4'(rand_bits(2)));
    load_unit(3, 4'(rand_bits(2)));
    drive_ports();
    @(posedge clk);
    iv[2] = 1'b0;
    iv[3] = 1'b0;
    drive_ports();
    @(posedge clk);
    load_unit(0, 4'(rand_bits(3)));
    load_unit(1, 4'(rand_bits(3)));
    drive_ports();
    @(posedge clk);
    iv[0] = 1'b0;
    iv[1] = 1'b0;
    load_unit(4, 4'd0);
    drive_ports();
    @(posedge clk);
    iv[4] = 1'b0;
    drive_ports();
    for (int k = 0; k < 5; k++) begin
      @(negedge clk);
      compare_flag(wb_valid, 1'b1, "burst valid");
      compare_result(bus_value(), exp_u[order[k]], "burst priority order");
    end
    // keep every source busy so the staging backs up
    for (int cyc = 0; cyc < 200; cyc++) begin
      @(negedge clk);
      if (wb_valid && exp_by_id.exists(wb_robid)) begin
        compare_result(bus_value(), exp_by_id[wb_robid], "contention result");
        exp_by_id.delete(wb_robid);
      end else if (wb_valid) begin
        errors++;
        $display("MISMATCH at %0t: unexpected or repeated robid %0d", $time, wb_robid);
      end
      busy = 1'b0;
      for (int u = 0; u < 5; u++) begin
        if (iv[u] && unit_ready(u)) begin
          exp_by_id[iid[u]] = exp_u[u];
          iv[u] = 1'b0;
        end
        if (!iv[u] && cyc < 30) begin
          load_unit(u, 4'(rand_bits(4)));
        end
        busy = busy | iv[u];
      end
      if (!busy && exp_by_id.num() == 0) begin
        break;
      end
      @(posedge clk);
      drive_ports();
    end
    if (exp_by_id.num() != 0) begin
      errors++;
      $display("timeout: %0d results never reached the bus", exp_by_id.num());
    end
    finish_test("priority and back-pressure", err0);
  endtask

  task automatic test_csr_merge();
    int err0;
    wb_pkg::wb_result_t csr_exp;
    err0 = errors;
    @(posedge clk);
    load_unit(0, 4'(wb_pkg::ALU_ADD));
    drive_ports();
    @(posedge clk);
    iv[0] = 1'b0;
    drive_ports();
    // csr lands while the alu0 result waits at its output
    csr_exp = '0;
    csr_exp.error = 1'b1;
    csr_exp.ecause = 5'd7;
    csr_exp.robid = next_id;
    csr_exp.rd = 6'd9;
    csr_exp.result = rand_bits(32);
    next_id = next_id + 8'd1;
    csr_valid <= 1'b1;
    csr_error <= csr_exp.error;
    csr_ecause <= csr_exp.ecause;
    csr_robid <= csr_exp.robid;
    csr_rd <= csr_exp.rd;
    csr_result <= csr_exp.result;
    @(negedge clk);
    compare_flag(alu0_ready, 1'b0, "alu0 held during csr write");
    compare_flag(wb_valid, 1'b0, "bus idle before csr");
    @(posedge clk);
    csr_valid <= 1'b0;
    @(negedge clk);
    compare_flag(wb_valid, 1'b1, "csr valid");
    compare_result(bus_value(), csr_exp, "csr result");
    @(negedge clk);
    compare_flag(wb_valid, 1'b1, "delayed alu0 valid");
    compare_result(bus_value(), exp_u[0], "delayed alu0 result");
    finish_test("csr merge", err0);
  endtask

  task automatic test_flush();
    int err0;
    err0 = errors;
    // two issue rounds, so alu0 is stalled behind alu1 when the flush comes
    for (int r = 0; r < 2; r++) begin
      @(posedge clk);
      for (int u = 0; u < 4; u++) begin
        load_unit(u, 4'd1);
      end
      drive_ports();
    end
    @(posedge clk);
    for (int u = 0; u < 4; u++) begin
      iv[u] = 1'b0;
    end
    drive_ports();
    rob_flush <= 1'b1;
    @(negedge clk);
    compare_flag(alu0_ready, 1'b0, "alu0 stalled before flush");
    @(posedge clk);
    rob_flush <= 1'b0;
    @(negedge clk);
    for (int u = 0; u < 4; u++) begin
      compare_flag(unit_ready(u), 1'b1, "ready after flush");
    end
    compare_flag(wb_valid, 1'b0, "bus after flush");
    for (int k = 0; k < 9; k++) begin
      @(negedge clk);
      compare_flag(wb_valid, 1'b0, "bus after flush");
    end
    finish_test("flush", err0);
  endtask

  initial begin
    lfsr_q = 32'h14fa;
    next_id = '0;
    errors = 0;
    tests = 0;
    failed = 0;
    for (int u = 0; u < 5; u++) begin
      iv[u] = 1'b0;
      iop[u] = '0;
      ia[u] = '0;
      ib[u] = '0;
      iid[u] = '0;
    end
    rst <= 1'b1;
    rob_flush <= 1'b0;
    csr_valid <= 1'b0;
    csr_error <= 1'b0;
    csr_ecause <= '0;
    csr_robid <= '0;
    csr_rd <= '0;
    csr_result <= '0;
    drive_ports();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_alu_ops();
    test_mul_stream();
    test_contention();
    test_csr_merge();
    test_flush();
    $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== logic/exec_cluster.sv ====
`timescale 1ns/1ps
/* execute and writeback cluster, two ALUs and two multipliers
   sharing the common data bus with the LSQ and CSR ports */
module exec_cluster #(
  parameter int MUL_STAGES = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rob_flush,
  input  logic               alu0_valid,
  input  wb_pkg::alu_op_t    alu0_op,
  input  core_pkg::word_t    alu0_a,
  input  core_pkg::word_t    alu0_b,
  input  core_pkg::robid_t   alu0_robid,
  input  core_pkg::preg_t    alu0_rd,
  output logic               alu0_ready,
  input  logic               alu1_valid,
  input  wb_pkg::alu_op_t    alu1_op,
  input  core_pkg::word_t    alu1_a,
  input  core_pkg::word_t    alu1_b,
  input  core_pkg::robid_t   alu1_robid,
  input  core_pkg::preg_t    alu1_rd,
  output logic               alu1_ready,
  input  logic               mul0_valid,
  input  wb_pkg::mul_op_t    mul0_op,
  input  core_pkg::word_t    mul0_a,
  input  core_pkg::word_t    mul0_b,
  input  core_pkg::robid_t   mul0_robid,
  input  core_pkg::preg_t    mul0_rd,
  output logic               mul0_ready,
  input  logic               mul1_valid,
  input  wb_pkg::mul_op_t    mul1_op,
  input  core_pkg::word_t    mul1_a,
  input  core_pkg::word_t    mul1_b,
  input  core_pkg::robid_t   mul1_robid,
  input  core_pkg::preg_t    mul1_rd,
  output logic               mul1_ready,
  input  logic               lsq_valid,
  input  logic               lsq_error,
  input  core_pkg::ecause_t  lsq_ecause,
  input  core_pkg::robid_t   lsq_robid,
  input  core_pkg::preg_t    lsq_rd,
  input  core_pkg::word_t    lsq_result,
  output logic               lsq_stall,
  input  logic               csr_valid,
  input  logic               csr_error,
  input  core_pkg::ecause_t  csr_ecause,
  input  core_pkg::robid_t   csr_robid,
  input  core_pkg::preg_t    csr_rd,
  input  core_pkg::word_t    csr_result,
  output logic               wb_valid,
  output logic               wb_error,
  output core_pkg::ecause_t  wb_ecause,
  output core_pkg::robid_t   wb_robid,
  output core_pkg::preg_t    wb_rd,
  output core_pkg::word_t    wb_result
);

  localparam int N_SRC = 5;

  wb_pkg::wb_result_t csr_res;
  wb_pkg::wb_result_t wb_res;

  fu_result_if src_if [N_SRC] ();

  scalar_alu u_alu0 (
    .clk(clk), .rst(rst), .flush(rob_flush),
    .issue_valid(alu0_valid), .issue_op(alu0_op),
    .issue_a(alu0_a), .issue_b(alu0_b),
    .issue_robid(alu0_robid), .issue_rd(alu0_rd),
    .issue_ready(alu0_ready), .out(src_if[wb_pkg::SRC_ALU0])
  );

  scalar_alu u_alu1 (
    .clk(clk), .rst(rst), .flush(rob_flush),
    .issue_valid(alu1_valid), .issue_op(alu1_op),
    .issue_a(alu1_a), .issue_b(alu1_b),
    .issue_robid(alu1_robid), .issue_rd(alu1_rd),
    .issue_ready(alu1_ready), .out(src_if[wb_pkg::SRC_ALU1])
  );

  mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul0 (
    .clk(clk), .rst(rst), .flush(rob_flush),
    .issue_valid(mul0_valid), .issue_op(mul0_op),
    .issue_a(mul0_a), .issue_b(mul0_b),
    .issue_robid(mul0_robid), .issue_rd(mul0_rd),
    .issue_ready(mul0_ready), .out(src_if[wb_pkg::SRC_MUL0])
  );

  mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul1 (
    .clk(clk), .rst(rst), .flush(rob_flush),
    .issue_valid(mul1_valid), .issue_op(mul1_op),
    .issue_a(mul1_a), .issue_b(mul1_b),
    .issue_robid(mul1_robid), .issue_rd(mul1_rd),
    .issue_ready(mul1_ready), .out(src_if[wb_pkg::SRC_MUL1])
  );

  // lsq result enters as the fifth source
  assign src_if[wb_pkg::SRC_LSQ].valid = lsq_valid;
  assign src_if[wb_pkg::SRC_LSQ].res = {lsq_error, lsq_ecause, lsq_robid, lsq_rd, lsq_result};
  assign lsq_stall = src_if[wb_pkg::SRC_LSQ].stall;

  assign csr_res = {csr_error, csr_ecause, csr_robid, csr_rd, csr_result};

  wb_arbiter #(.N_SRC(N_SRC)) u_arb (
    .clk(clk), .rst(rst), .flush(rob_flush),
    .src(src_if),
    .csr_valid(csr_valid), .csr_res(csr_res),
    .wb_valid(wb_valid), .wb_res(wb_res)
  );

  assign {wb_error, wb_ecause, wb_robid, wb_rd, wb_result} = wb_res;

endmodule

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ps
/* writeback arbiter, stages one result per source and grants the
   common data bus by fixed priority, highest index first */
module wb_arbiter #(
  parameter int N_SRC = 5
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  fu_result_if.consumer      src [N_SRC],
  input  logic               csr_valid,
  input  wb_pkg::wb_result_t csr_res,
  output logic               wb_valid,
  output wb_pkg::wb_result_t wb_res
);

  logic [N_SRC-1:0]   stg_valid;
  wb_pkg::wb_result_t stg_res [N_SRC];
  logic [N_SRC-1:0]   in_valid;
  wb_pkg::wb_result_t in_res [N_SRC];
  logic [N_SRC-1:0]   ld;
  logic [N_SRC-1:0]   grant;

  for (genvar i = 0; i < N_SRC; i++) begin : g_src
    // staging accepts when empty or leaving this cycle
    assign ld[i] = !stg_valid[i] || grant[i];

    if (i == 0) begin : g_csr
      // csr shares slot 0 and pushes alu0 back
      assign in_valid[i] = csr_valid || src[i].valid;
      assign in_res[i] = csr_valid ? csr_res : src[i].res;
      assign src[i].stall = (stg_valid[i] && !grant[i]) || csr_valid;
    end else begin : g_fu
      assign in_valid[i] = src[i].valid;
      assign in_res[i] = src[i].res;
      assign src[i].stall = stg_valid[i] && !grant[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stg_valid <= '0;
    end else if (flush) begin
      stg_valid <= '0;
    end else begin
      for (int i = 0; i < N_SRC; i++) begin
        if (ld[i]) begin
          stg_valid[i] <= in_valid[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N_SRC; i++) begin
      if (ld[i] && in_valid[i]) begin
        stg_res[i] <= in_res[i];
      end
    end
  end

  // later match overrides, so the highest staged index wins
  always_comb begin
    grant = '0;
    wb_res = '0;
    for (int i = 0; i < N_SRC; i++) begin
      if (stg_valid[i]) begin
        grant = '0;
        grant[i] = 1'b1;
        wb_res = stg_res[i];
      end
    end
  end

  assign wb_valid = |stg_valid;

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && (wb_valid == (|grant)));

  // csr has no stall, so slot 0 must be free or leaving
  a_csr_slot_free: assert property (@(posedge clk) disable iff (rst)
    csr_valid |-> ld[0]);

endmodule

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ps
/* pipelined 32-bit multiplier, low and high products,
   whole pipeline freezes under back-pressure */
module mul_unit #(
  parameter int MUL_STAGES = 3
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush,
  input  logic             issue_valid,
  input  wb_pkg::mul_op_t  issue_op,
  input  core_pkg::word_t  issue_a,
  input  core_pkg::word_t  issue_b,
  input  core_pkg::robid_t issue_robid,
  input  core_pkg::preg_t  issue_rd,
  output logic             issue_ready,
  fu_result_if.producer    out
);

  localparam int W = core_pkg::XLEN;
  localparam int LAST = MUL_STAGES - 1;

  logic [MUL_STAGES-1:0] v;
  logic [2*W-1:0]        prod_q [MUL_STAGES];
  wb_pkg::mul_op_t       op_q [MUL_STAGES];
  core_pkg::robid_t      robid_q [MUL_STAGES];
  core_pkg::preg_t       rd_q [MUL_STAGES];
  logic [2*W-1:0]        ext_a;
  logic [2*W-1:0]        ext_b;
  logic                  advance;
  wb_pkg::wb_result_t    mul_res;

  // only MULH treats operands as signed
  assign ext_a = (issue_op == wb_pkg::OP_MULH) ?
                 {{W{issue_a[W-1]}}, issue_a} : {{W{1'b0}}, issue_a};
  assign ext_b = (issue_op == wb_pkg::OP_MULH) ?
                 {{W{issue_b[W-1]}}, issue_b} : {{W{1'b0}}, issue_b};

  assign advance = !v[LAST] || !out.stall;
  assign issue_ready = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      v <= '0;
    end else if (flush) begin
      v <= '0;
    end else if (advance) begin
      v <= {v[MUL_STAGES-2:0], issue_valid};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      prod_q[0] <= ext_a * ext_b;
      op_q[0] <= issue_op;
      robid_q[0] <= issue_robid;
      rd_q[0] <= issue_rd;
      for (int i = 1; i < MUL_STAGES; i++) begin
        prod_q[i] <= prod_q[i-1];
        op_q[i] <= op_q[i-1];
        robid_q[i] <= robid_q[i-1];
        rd_q[i] <= rd_q[i-1];
      end
    end
  end

  // half select at the last stage
  always_comb begin
    mul_res = '0;
    mul_res.robid = robid_q[LAST];
    mul_res.rd = rd_q[LAST];
    case (op_q[LAST])
      wb_pkg::OP_MUL: mul_res.result = prod_q[LAST][W-1:0];
      wb_pkg::OP_MULH, wb_pkg::OP_MULHU: mul_res.result = prod_q[LAST][2*W-1:W];
      default: begin
        mul_res.error = 1'b1;
        mul_res.ecause = core_pkg::ECAUSE_ILLEGAL_INSN;
      end
    endcase
  end

  assign out.valid = v[LAST];
  assign out.res = mul_res;

  a_no_ready_when_stuck: assert property (@(posedge clk) disable iff (rst)
    !(issue_ready && out.valid && out.stall));

endmodule

// ==== logic/scalar_alu.sv ====
`timescale 1ns/1ps
/* single-cycle integer ALU, result register held under stall */
module scalar_alu (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush,
  input  logic             issue_valid,
  input  wb_pkg::alu_op_t  issue_op,
  input  core_pkg::word_t  issue_a,
  input  core_pkg::word_t  issue_b,
  input  core_pkg::robid_t issue_robid,
  input  core_pkg::preg_t  issue_rd,
  output logic             issue_ready,
  fu_result_if.producer    out
);

  wb_pkg::wb_result_t alu_res;

  assign issue_ready = !(out.valid && out.stall);

  always_comb begin
    alu_res = '0;
    alu_res.robid = issue_robid;
    alu_res.rd = issue_rd;
    case (issue_op)
      wb_pkg::ALU_ADD: alu_res.result = issue_a + issue_b;
      wb_pkg::ALU_SUB: alu_res.result = issue_a - issue_b;
      wb_pkg::ALU_AND: alu_res.result = issue_a & issue_b;
      wb_pkg::ALU_OR:  alu_res.result = issue_a | issue_b;
      wb_pkg::ALU_XOR: alu_res.result = issue_a ^ issue_b;
      wb_pkg::ALU_SLL: alu_res.result = issue_a << issue_b[4:0];
      wb_pkg::ALU_SRL: alu_res.result = issue_a >> issue_b[4:0];
      wb_pkg::ALU_SLT: alu_res.result = core_pkg::word_t'($signed(issue_a) < $signed(issue_b));
      default: begin
        // data word stays zero
        alu_res.error = 1'b1;
        alu_res.ecause = core_pkg::ECAUSE_ILLEGAL_INSN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else if (flush) begin
      out.valid <= 1'b0;
    end else if (issue_ready) begin
      out.valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_ready && issue_valid) begin
      out.res <= alu_res;
    end
  end

  // a stalled result stays put until the arbiter takes it
  a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    out.valid && out.stall && !flush |=> out.valid && $stable(out.res));

endmodule

// ==== logic/fu_result_if.sv ====
`timescale 1ns/1ps
/* functional unit result channel with valid/stall handshake */
interface fu_result_if;

  logic               valid;
  logic               stall;
  wb_pkg::wb_result_t res;

  // producer holds valid and res while stall is high
  modport producer (
    output valid,
    output res,
    input  stall
  );

  modport consumer (
    input  valid,
    input  res,
    output stall
  );

endinterface

// ==== logic/wb_pkg.sv ====
/* writeback result record, ALU and multiplier opcodes,
   and the source indices of the common data bus */
package wb_pkg;

  // one result as it travels to the common data bus
  typedef struct packed {
    logic              error;
    core_pkg::ecause_t ecause;
    core_pkg::robid_t  robid;
    core_pkg::preg_t   rd;
    core_pkg::word_t   result;
  } wb_result_t;

  // codes 8 to 15 are illegal
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SLT = 4'd7
  } alu_op_t;

  // code 3 is illegal
  typedef enum logic [1:0] {
    OP_MUL   = 2'd0,
    OP_MULH  = 2'd1,
    OP_MULHU = 2'd2
  } mul_op_t;

  // higher index wins the bus
  localparam int SRC_ALU0 = 0;
  localparam int SRC_ALU1 = 1;
  localparam int SRC_MUL0 = 2;
  localparam int SRC_MUL1 = 3;
  localparam int SRC_LSQ  = 4;

endpackage

// ==== logic/core_pkg.sv ====
/* core-wide widths and types for ROB ids, physical registers,
   data words and exception causes */
package core_pkg;

  // data path width
  localparam int XLEN = 32;

  // ROB entry id
  typedef logic [7:0] robid_t;

  // physical destination register
  typedef logic [5:0] preg_t;

  typedef logic [XLEN-1:0] word_t;

  // exception cause code
  typedef logic [4:0] ecause_t;

  // reported for opcodes a unit cannot execute
  localparam ecause_t ECAUSE_ILLEGAL_INSN = 5'd2;

endpackage
